//--- bus_pkg.sv
/*
 Shared widths, address map constants and FSM encodings for the
 main-bus core. Modules refer to these through scoped names.
*/
`default_nettype none

package bus_pkg;

	// ------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------
	// Main-bus word address, byte address bits 23..1
	typedef logic [22:0] addr_t;
	typedef logic [15:0] data_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] zaddr_t;
	typedef logic [14:0] zbaddr_t;

	// 64 KB work RAM, 8 KB Z80 RAM
	localparam int WRAM_AW = 15;
	localparam int ZRAM_AW = 13;

	// Value seen on an undriven bus, a NOP opcode
	localparam data_t OPEN_BUS_INIT = 16'h4E71;

	// ------------------------------------------------------------
	// Address map
	// ------------------------------------------------------------
	localparam logic [23:0] ROM_LIMIT        = 24'hA00000;
	localparam logic [7:0]  ZBUS_WINDOW      = 8'hA0;
	localparam logic [23:0] CTRL_BUSREQ_ADDR = 24'hA11100;
	localparam logic [23:0] CTRL_RESET_ADDR  = 24'hA11200;
	localparam logic [2:0]  WRAM_BASE        = 3'b111;
	// Z80 bank register page, 6000-60FF
	localparam logic [6:0]  Z80_BANK_PAGE    = 7'h60;

	// ------------------------------------------------------------
	// FSM encodings
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		MB_IDLE,
		MB_SELECT,
		MB_RAM_READ,
		MB_ROM_READ,
		MB_ZBUS_WAIT,
		MB_FINISH
	} mbus_state_e;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_HOST,
		SRC_Z80
	} msrc_e;

	typedef enum logic [1:0] {
		ZB_IDLE,
		ZB_ACCESS,
		ZB_FINISH
	} zbus_state_e;

	typedef enum logic {
		ZSRC_MBUS,
		ZSRC_Z80
	} zsrc_e;

endpackage

`default_nettype wire

//--- work_ram.sv
/*
 Main-bus work RAM, 64 KB as two byte lanes.
 Each lane has its own write enable; read data lags the address by one clock.
*/
`timescale 1ns/1ps
`default_nettype none

module work_ram (
	input  logic                        MCLK,
	input  logic [bus_pkg::WRAM_AW-1:0] addr,
	input  logic                        we_hi,
	input  logic                        we_lo,
	input  bus_pkg::data_t              wdata,
	output bus_pkg::data_t              rdata
);

	bus_pkg::data_t mem [2**bus_pkg::WRAM_AW];

	// Byte-lane writes
	always_ff @(posedge MCLK) begin
		if (we_hi) begin
			mem[addr][15:8] <= wdata[15:8];
		end
		if (we_lo) begin
			mem[addr][7:0] <= wdata[7:0];
		end
	end

	// Registered read, returns the old word on a write cycle
	always_ff @(posedge MCLK) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

//--- zbus_bridge.sv
/*
 Z80-side bus. Serves main-bus accesses to the Z80 window and local Z80
 accesses (Z80 RAM, bank register), and forwards banked Z80 accesses
 from 8000 up onto the main bus.
*/
`timescale 1ns/1ps
`default_nettype none

module zbus_bridge (
	input  logic             MCLK,
	input  logic             reset,
	// Z80 port
	input  logic             z80_cyc,
	input  logic             z80_stb,
	input  logic             z80_we,
	input  bus_pkg::zaddr_t  z80_adr,
	input  bus_pkg::byte_t   z80_dat_w,
	output bus_pkg::byte_t   z80_dat_r,
	output logic             z80_ack,
	// Main bus into the Z80 window
	input  logic             zb_req,
	input  logic             zb_we,
	input  bus_pkg::zbaddr_t zb_adr,
	input  bus_pkg::byte_t   zb_dat_w,
	output bus_pkg::byte_t   zb_dat_r,
	output logic             zb_ack,
	// Banked Z80 access out to the main bus
	output logic             zm_req,
	output logic             zm_we,
	output bus_pkg::addr_t   zm_adr,
	output logic             zm_hi,
	output bus_pkg::byte_t   zm_dat_w,
	input  bus_pkg::byte_t   zm_dat_r,
	input  logic             zm_ack,
	// Z80 control
	input  logic             z80_busreq_n,
	input  logic             z80_reset_n
);

	bus_pkg::zbus_state_e state;
	bus_pkg::zsrc_e       zsrc;

	// Latched access
	bus_pkg::zbaddr_t za;
	bus_pkg::byte_t   zd;
	logic             zwe;
	logic             zfwd;
	logic             zdeny;
	logic             phase;
	bus_pkg::byte_t   rd_byte;

	logic [8:0]       bank;

	bus_pkg::byte_t   zram [2**bus_pkg::ZRAM_AW];
	bus_pkg::byte_t   zram_q;

	logic mbus_owns;
	logic z80_run;
	logic z80_go;
	logic zram_sel;
	logic bank_sel;
	logic zram_we;

	// Main bus holds the Z80 bus only with the Z80 out of reset and halted
	assign mbus_owns = ~z80_busreq_n & z80_reset_n;
	assign z80_run   = z80_busreq_n & z80_reset_n;
	assign z80_go    = z80_cyc & z80_stb & ~z80_ack & z80_run;

	// 0000-1FFF, mirrored at 2000-3FFF
	assign zram_sel = ~za[14];
	assign bank_sel = za[14:8] == bus_pkg::Z80_BANK_PAGE;
	assign zram_we  = (state == bus_pkg::ZB_ACCESS) & ~phase & ~zfwd & zwe & zram_sel;

	// Bank register on top, Z80 address 14..1 below
	assign zm_adr   = {bank, za[14:1]};
	assign zm_hi    = ~za[0];
	assign zm_we    = zwe;
	assign zm_dat_w = zd;

	// ------------------------------------------------------------
	// Z80 RAM
	// ------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (zram_we) begin
			zram[za[bus_pkg::ZRAM_AW-1:0]] <= zd;
		end
		zram_q <= zram[za[bus_pkg::ZRAM_AW-1:0]];
	end

	// ------------------------------------------------------------
	// Access FSM
	// ------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state   <= bus_pkg::ZB_IDLE;
			zsrc    <= bus_pkg::ZSRC_MBUS;
			zb_ack  <= 1'b0;
			z80_ack <= 1'b0;
			zm_req  <= 1'b0;
			phase   <= 1'b0;
			bank    <= '0;
		end else begin
			zb_ack  <= 1'b0;
			z80_ack <= 1'b0;

			case (state)
				bus_pkg::ZB_IDLE: begin
					phase <= 1'b0;
					// Main bus first
					if (zb_req & ~zb_ack) begin
						za    <= zb_adr;
						zd    <= zb_dat_w;
						zwe   <= zb_we & mbus_owns;
						zdeny <= ~mbus_owns;
						zfwd  <= 1'b0;
						zsrc  <= bus_pkg::ZSRC_MBUS;
						state <= bus_pkg::ZB_ACCESS;
					end else if (z80_go) begin
						za     <= z80_adr[14:0];
						zd     <= z80_dat_w;
						zwe    <= z80_we;
						zdeny  <= 1'b0;
						zfwd   <= z80_adr[15];
						zm_req <= z80_adr[15];
						zsrc   <= bus_pkg::ZSRC_Z80;
						state  <= bus_pkg::ZB_ACCESS;
					end
				end

				bus_pkg::ZB_ACCESS: begin
					if (zfwd) begin
						// Banked access, wait for the main bus
						if (zm_ack) begin
							zm_req  <= 1'b0;
							rd_byte <= zm_dat_r;
							state   <= bus_pkg::ZB_FINISH;
						end
					end else if (!phase) begin
						// RAM cycle happens on this edge
						phase <= 1'b1;
						if (zwe & bank_sel) begin
							bank <= {zd[0], bank[8:1]};
						end
					end else begin
						rd_byte <= (zram_sel & ~zdeny) ? zram_q : 8'hFF;
						state   <= bus_pkg::ZB_FINISH;
					end
				end

				bus_pkg::ZB_FINISH: begin
					if (zsrc == bus_pkg::ZSRC_MBUS) begin
						zb_ack   <= 1'b1;
						zb_dat_r <= rd_byte;
					end else begin
						z80_ack   <= 1'b1;
						z80_dat_r <= rd_byte;
					end
					state <= bus_pkg::ZB_IDLE;
				end

				default: state <= bus_pkg::ZB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- main_bus_ctrl.sv
/*
 Main-bus controller. Arbitrates the host and banked Z80 accesses, decodes
 ROM, the Z80 window, the Z80 control registers and work RAM, and keeps the
 open-bus latch.
*/
`timescale 1ns/1ps
`default_nettype none

module main_bus_ctrl (
	input  logic                        MCLK,
	input  logic                        reset,
	// Host port
	input  logic                        host_cyc,
	input  logic                        host_stb,
	input  logic                        host_we,
	input  logic [1:0]                  host_sel,
	input  bus_pkg::addr_t              host_adr,
	input  bus_pkg::data_t              host_dat_w,
	output bus_pkg::data_t              host_dat_r,
	output logic                        host_ack,
	// Banked Z80 requests
	input  logic                        zm_req,
	input  logic                        zm_we,
	input  bus_pkg::addr_t              zm_adr,
	input  logic                        zm_hi,
	input  bus_pkg::byte_t              zm_dat_w,
	output bus_pkg::byte_t              zm_dat_r,
	output logic                        zm_ack,
	// Z80 window
	output logic                        zb_req,
	output logic                        zb_we,
	output bus_pkg::zbaddr_t            zb_adr,
	output bus_pkg::byte_t              zb_dat_w,
	input  bus_pkg::byte_t              zb_dat_r,
	input  logic                        zb_ack,
	// ROM, toggle handshake
	output logic                        rom_req,
	input  logic                        rom_ack,
	output bus_pkg::addr_t              rom_addr,
	input  bus_pkg::data_t              rom_data,
	input  bus_pkg::addr_t              rom_size,
	// Work RAM
	output logic [bus_pkg::WRAM_AW-1:0] wram_addr,
	output logic                        wram_we_hi,
	output logic                        wram_we_lo,
	output bus_pkg::data_t              wram_wdata,
	input  bus_pkg::data_t              wram_rdata,
	// Z80 control register
	output logic                        z80_busreq_n,
	output logic                        z80_reset_n
);

	bus_pkg::mbus_state_e state;
	bus_pkg::msrc_e       msrc;

	// Latched cycle
	bus_pkg::addr_t mb_adr;
	bus_pkg::data_t mb_dat_w;
	logic [1:0]     mb_sel;
	logic           mb_we;

	bus_pkg::data_t data;
	bus_pkg::data_t open_bus;

	logic        host_go;
	logic        zm_go;
	logic [23:0] mb_byte;
	logic        rom_area;
	logic        win_hit;
	logic        busreq_hit;
	logic        resreg_hit;
	logic        wram_hit;
	logic        ctrl_bit;

	// Ack still high means the master has not dropped stb yet
	assign host_go = host_cyc & host_stb & ~host_ack;
	assign zm_go   = zm_req & ~zm_ack;

	// ------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------
	assign mb_byte    = {mb_adr, 1'b0};
	assign rom_area   = mb_byte < bus_pkg::ROM_LIMIT;
	assign win_hit    = mb_byte[23:16] == bus_pkg::ZBUS_WINDOW;
	assign busreq_hit = (mb_byte[23:8] == bus_pkg::CTRL_BUSREQ_ADDR[23:8]) &
		(mb_byte[7:1] == 7'd0);
	assign resreg_hit = (mb_byte[23:8] == bus_pkg::CTRL_RESET_ADDR[23:8]) &
		(mb_byte[7:1] == 7'd0);
	assign wram_hit   = mb_byte[23:21] == bus_pkg::WRAM_BASE;
	assign ctrl_bit   = busreq_hit ? z80_busreq_n : z80_reset_n;

	assign rom_addr = mb_adr;

	assign wram_addr  = mb_adr[bus_pkg::WRAM_AW-1:0];
	assign wram_wdata = mb_dat_w;
	assign wram_we_hi = (state == bus_pkg::MB_SELECT) & wram_hit & mb_we & mb_sel[1];
	assign wram_we_lo = (state == bus_pkg::MB_SELECT) & wram_hit & mb_we & mb_sel[0];

	// Byte address bit 0 is set for the lower lane
	assign zb_we    = mb_we;
	assign zb_adr   = {mb_adr[13:0], ~mb_sel[1]};
	assign zb_dat_w = mb_sel[1] ? mb_dat_w[15:8] : mb_dat_w[7:0];

	// ------------------------------------------------------------
	// Bus FSM
	// ------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= bus_pkg::MB_IDLE;
			msrc         <= bus_pkg::SRC_NONE;
			host_ack     <= 1'b0;
			zm_ack       <= 1'b0;
			zb_req       <= 1'b0;
			rom_req      <= 1'b0;
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
			open_bus     <= bus_pkg::OPEN_BUS_INIT;
		end else begin
			host_ack <= 1'b0;
			zm_ack   <= 1'b0;

			case (state)
				bus_pkg::MB_IDLE: begin
					if (host_go) begin
						msrc     <= bus_pkg::SRC_HOST;
						mb_adr   <= host_adr;
						mb_we    <= host_we;
						mb_sel   <= host_sel;
						mb_dat_w <= host_dat_w;
						data     <= open_bus;
						state    <= bus_pkg::MB_SELECT;
					end else if (zm_go) begin
						msrc     <= bus_pkg::SRC_Z80;
						mb_adr   <= zm_adr;
						mb_we    <= zm_we;
						mb_sel   <= {zm_hi, ~zm_hi};
						mb_dat_w <= {zm_dat_w, zm_dat_w};
						// Z80 sees all ones on unmapped reads
						data     <= 16'hFFFF;
						state    <= bus_pkg::MB_SELECT;
					end
				end

				bus_pkg::MB_SELECT: begin
					state <= bus_pkg::MB_FINISH;
					if (rom_area) begin
						if (mb_adr < rom_size && !mb_we) begin
							rom_req <= ~rom_ack;
							state   <= bus_pkg::MB_ROM_READ;
						end else begin
							data <= '0;
						end
					end else if (win_hit && msrc == bus_pkg::SRC_HOST) begin
						// Z80 window, not reachable from the Z80 itself
						zb_req <= 1'b1;
						state  <= bus_pkg::MB_ZBUS_WAIT;
					end else if (busreq_hit | resreg_hit) begin
						if (mb_we & mb_sel[1]) begin
							if (busreq_hit) begin
								z80_busreq_n <= ~mb_dat_w[8];
							end else begin
								z80_reset_n <= mb_dat_w[8];
							end
						end
						data <= {open_bus[15:9], ctrl_bit, open_bus[7:0]};
					end else if (wram_hit) begin
						state <= bus_pkg::MB_RAM_READ;
					end
				end

				bus_pkg::MB_RAM_READ: begin
					data <= wram_rdata;
					if (msrc == bus_pkg::SRC_HOST && !mb_we) begin
						open_bus <= wram_rdata;
					end
					state <= bus_pkg::MB_FINISH;
				end

				bus_pkg::MB_ROM_READ: begin
					if (rom_req == rom_ack) begin
						data <= rom_data;
						if (msrc == bus_pkg::SRC_HOST) begin
							open_bus <= rom_data;
						end
						state <= bus_pkg::MB_FINISH;
					end
				end

				bus_pkg::MB_ZBUS_WAIT: begin
					if (zb_ack) begin
						zb_req <= 1'b0;
						data   <= {zb_dat_r, zb_dat_r};
						state  <= bus_pkg::MB_FINISH;
					end
				end

				bus_pkg::MB_FINISH: begin
					if (msrc == bus_pkg::SRC_HOST) begin
						host_ack   <= 1'b1;
						host_dat_r <= data;
					end else begin
						zm_ack   <= 1'b1;
						zm_dat_r <= mb_sel[1] ? data[15:8] : data[7:0];
					end
					msrc  <= bus_pkg::SRC_NONE;
					state <= bus_pkg::MB_IDLE;
				end

				default: state <= bus_pkg::MB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- genesis_bus_top.sv
/*
 Top of the main-bus core. Connects the bus controller, the work RAM and
 the Z-bus bridge; the host and Z80 ports are Wishbone classic.
*/
`timescale 1ns/1ps
`default_nettype none

module genesis_bus_top (
	input  logic            MCLK,
	input  logic            reset,
	// Host port
	input  logic            host_cyc,
	input  logic            host_stb,
	input  logic            host_we,
	input  logic [1:0]      host_sel,
	input  bus_pkg::addr_t  host_adr,
	input  bus_pkg::data_t  host_dat_w,
	output bus_pkg::data_t  host_dat_r,
	output logic            host_ack,
	// Z80 port
	input  logic            z80_cyc,
	input  logic            z80_stb,
	input  logic            z80_we,
	input  bus_pkg::zaddr_t z80_adr,
	input  bus_pkg::byte_t  z80_dat_w,
	output bus_pkg::byte_t  z80_dat_r,
	output logic            z80_ack,
	// ROM port
	output logic            rom_req,
	input  logic            rom_ack,
	output bus_pkg::addr_t  rom_addr,
	input  bus_pkg::data_t  rom_data,
	input  bus_pkg::addr_t  rom_size,
	// Z80 control
	output logic            z80_busreq_n,
	output logic            z80_reset_n
);

	// Bridge to controller
	logic             zm_req;
	logic             zm_we;
	bus_pkg::addr_t   zm_adr;
	logic             zm_hi;
	bus_pkg::byte_t   zm_dat_w;
	bus_pkg::byte_t   zm_dat_r;
	logic             zm_ack;

	// Controller to bridge
	logic             zb_req;
	logic             zb_we;
	bus_pkg::zbaddr_t zb_adr;
	bus_pkg::byte_t   zb_dat_w;
	bus_pkg::byte_t   zb_dat_r;
	logic             zb_ack;

	// Work RAM
	logic [bus_pkg::WRAM_AW-1:0] wram_addr;
	logic             wram_we_hi;
	logic             wram_we_lo;
	bus_pkg::data_t   wram_wdata;
	bus_pkg::data_t   wram_rdata;

	main_bus_ctrl u_ctrl (
		.MCLK(MCLK),
		.reset(reset),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_sel(host_sel),
		.host_adr(host_adr),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.zm_req(zm_req),
		.zm_we(zm_we),
		.zm_adr(zm_adr),
		.zm_hi(zm_hi),
		.zm_dat_w(zm_dat_w),
		.zm_dat_r(zm_dat_r),
		.zm_ack(zm_ack),
		.zb_req(zb_req),
		.zb_we(zb_we),
		.zb_adr(zb_adr),
		.zb_dat_w(zb_dat_w),
		.zb_dat_r(zb_dat_r),
		.zb_ack(zb_ack),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.rom_size(rom_size),
		.wram_addr(wram_addr),
		.wram_we_hi(wram_we_hi),
		.wram_we_lo(wram_we_lo),
		.wram_wdata(wram_wdata),
		.wram_rdata(wram_rdata),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	work_ram u_wram (
		.MCLK(MCLK),
		.addr(wram_addr),
		.we_hi(wram_we_hi),
		.we_lo(wram_we_lo),
		.wdata(wram_wdata),
		.rdata(wram_rdata)
	);

	zbus_bridge u_zbus (
		.MCLK(MCLK),
		.reset(reset),
		.z80_cyc(z80_cyc),
		.z80_stb(z80_stb),
		.z80_we(z80_we),
		.z80_adr(z80_adr),
		.z80_dat_w(z80_dat_w),
		.z80_dat_r(z80_dat_r),
		.z80_ack(z80_ack),
		.zb_req(zb_req),
		.zb_we(zb_we),
		.zb_adr(zb_adr),
		.zb_dat_w(zb_dat_w),
		.zb_dat_r(zb_dat_r),
		.zb_ack(zb_ack),
		.zm_req(zm_req),
		.zm_we(zm_we),
		.zm_adr(zm_adr),
		.zm_hi(zm_hi),
		.zm_dat_w(zm_dat_w),
		.zm_dat_r(zm_dat_r),
		.zm_ack(zm_ack),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

endmodule

`default_nettype wire

//--- tb_genesis_bus.sv
/*
 Testbench for the main-bus core. Reads host and Z80 bus operations with
 their expected results from bus_stim.txt and runs them through the DUT,
 with a ROM model that answers after random delays.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_genesis_bus;

	localparam int WAIT_LIMIT = 200;

	logic             MCLK;
	logic             reset;
	logic             host_cyc;
	logic             host_stb;
	logic             host_we;
	logic [1:0]       host_sel;
	bus_pkg::addr_t   host_adr;
	bus_pkg::data_t   host_dat_w;
	bus_pkg::data_t   host_dat_r;
	logic             host_ack;
	logic             z80_cyc;
	logic             z80_stb;
	logic             z80_we;
	bus_pkg::zaddr_t  z80_adr;
	bus_pkg::byte_t   z80_dat_w;
	bus_pkg::byte_t   z80_dat_r;
	logic             z80_ack;
	logic             rom_req;
	logic             rom_ack = 1'b0;
	bus_pkg::addr_t   rom_addr;
	bus_pkg::data_t   rom_data = 16'h0000;
	bus_pkg::addr_t   rom_size;
	logic             z80_busreq_n;
	logic             z80_reset_n;

	// ROM model state
	logic [15:0]      lfsr = 16'd11952;
	logic             rom_busy = 1'b0;
	logic [7:0]       rom_delay = 8'h00;

	// Current stimulus line
	string            line;
	logic [7:0]       port;
	logic [7:0]       op;
	logic [23:0]      addr;
	logic [1:0]       mask;
	logic [15:0]      wdat;
	logic [15:0]      expv;
	int               fd;
	int               count;
	int               lineno;
	int               ops_run;

	genesis_bus_top u_dut (
		.MCLK(MCLK),
		.reset(reset),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_sel(host_sel),
		.host_adr(host_adr),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.z80_cyc(z80_cyc),
		.z80_stb(z80_stb),
		.z80_we(z80_we),
		.z80_adr(z80_adr),
		.z80_dat_w(z80_dat_w),
		.z80_dat_r(z80_dat_r),
		.z80_ack(z80_ack),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.rom_size(rom_size),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	initial begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;
	end

	// ------------------------------------------------------------
	// Random source and ROM model
	// ------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end else begin
			return state >> 1;
		end
	endfunction

	task automatic draw_bits(input int nbits, output logic [7:0] value);
		int i;
		value = 8'h00;
		for (i = 0; i < nbits; i++) begin
			value = {value[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Answers 1 to 8 cycles after a new request
	always @(negedge MCLK) begin
		if (rom_req != rom_ack) begin
			if (!rom_busy) begin
				draw_bits(3, rom_delay);
				rom_busy = 1'b1;
			end else if (rom_delay != 8'h00) begin
				rom_delay = rom_delay - 8'd1;
			end else begin
				rom_data = rom_addr[15:0] ^ 16'hA5C3;
				rom_ack  = rom_req;
				rom_busy = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input bus_pkg::data_t exp,
			input bus_pkg::data_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_byte(input string name, input bus_pkg::byte_t exp,
			input bus_pkg::byte_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// ------------------------------------------------------------
	// Bus masters that start on a falling edge
	// ------------------------------------------------------------
	task automatic host_cycle(input logic we, input logic [1:0] sel,
			input logic [23:0] byte_adr, input bus_pkg::data_t wr,
			output bus_pkg::data_t rd);
		int waited;
		waited     = 0;
		host_cyc   = 1'b1;
		host_stb   = 1'b1;
		host_we    = we;
		host_sel   = sel;
		host_adr   = byte_adr[23:1];
		host_dat_w = wr;
		@(negedge MCLK);
		while (!host_ack) begin
			if (waited == WAIT_LIMIT) begin
				stop_on_error("Host port got no ack within the time limit");
			end
			waited++;
			@(negedge MCLK);
		end
		rd       = host_dat_r;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we  = 1'b0;
		@(negedge MCLK);
	endtask

	task automatic z80_cycle(input logic we, input bus_pkg::zaddr_t adr,
			input bus_pkg::byte_t wr, output bus_pkg::byte_t rd);
		int waited;
		waited    = 0;
		z80_cyc   = 1'b1;
		z80_stb   = 1'b1;
		z80_we    = we;
		z80_adr   = adr;
		z80_dat_w = wr;
		@(negedge MCLK);
		while (!z80_ack) begin
			if (waited == WAIT_LIMIT) begin
				stop_on_error("Z80 port got no ack within the time limit");
			end
			waited++;
			@(negedge MCLK);
		end
		rd      = z80_dat_r;
		z80_cyc = 1'b0;
		z80_stb = 1'b0;
		z80_we  = 1'b0;
		@(negedge MCLK);
	endtask

	// One stimulus line
	task automatic run_operation(input int num);
		string          name;
		bus_pkg::data_t rword;
		bus_pkg::byte_t rbyte;
		name = $sformatf("line %0d %c%c %h", num, port, op, addr);
		if (port == "H" && op == "W") begin
			host_cycle(1'b1, mask, addr, wdat, rword);
		end else if (port == "H" && op == "R") begin
			host_cycle(1'b0, mask, addr, 16'h0000, rword);
			check_word(name, expv, rword);
		end else if (port == "H" && op == "C") begin
			check_flag({name, " reset_n"}, expv[1], z80_reset_n);
			check_flag({name, " busreq_n"}, expv[0], z80_busreq_n);
		end else if (port == "Z" && op == "W") begin
			z80_cycle(1'b1, addr[15:0], wdat[7:0], rbyte);
		end else if (port == "Z" && op == "R") begin
			z80_cycle(1'b0, addr[15:0], 8'h00, rbyte);
			check_byte(name, expv[7:0], rbyte);
		end else begin
			stop_on_error($sformatf("Unknown operation in stimulus %s", name));
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		reset      = 1'b1;
		host_cyc   = 1'b0;
		host_stb   = 1'b0;
		host_we    = 1'b0;
		host_sel   = 2'b00;
		host_adr   = '0;
		host_dat_w = 16'h0000;
		z80_cyc    = 1'b0;
		z80_stb    = 1'b0;
		z80_we     = 1'b0;
		z80_adr    = 16'h0000;
		z80_dat_w  = 8'h00;
		// ROM ends at byte address 200000
		rom_size   = 23'h100000;
		repeat (4) @(negedge MCLK);
		reset = 1'b0;
		@(negedge MCLK);

		fd = $fopen("bus_stim.txt", "r");
		if (fd == 0) begin
			stop_on_error("Could not open the stimulus file bus_stim.txt");
		end
		lineno  = 0;
		ops_run = 0;
		while ($fgets(line, fd) != 0) begin
			lineno++;
			count = $sscanf(line, " %c %c %h %h %h %h", port, op, addr, mask, wdat, expv);
			// Skip comment and blank lines
			if (count == 6 && port != "#") begin
				run_operation(lineno);
				ops_run++;
			end
		end
		$fclose(fd);

		if (ops_run > 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_on_error("No operations found in the stimulus file");
		end
	end

endmodule

`default_nettype wire

//--- flist.f
bus_pkg.sv
work_ram.sv
zbus_bridge.sv
main_bus_ctrl.sv
genesis_bus_top.sv
tb_genesis_bus.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_genesis_bus -f flist.f -o tb_genesis_bus
	@out="$$(./obj_dir/tb_genesis_bus)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

//--- bus_stim.txt
# port (H host, Z Z80)  op (W write, R read, C check)  address (host byte / Z80)
# lane mask  write data  expected (C: bit 1 z80_reset_n, bit 0 z80_busreq_n)
H C 000000 0 0000 0001
H R A20000 3 0000 4E71
H W FF0100 3 1234 0000
H W FF0100 2 AB00 0000
H W FF0100 1 00CD 0000
H R FF0100 3 0000 ABCD
H R E10100 3 0000 ABCD
H R A20000 3 0000 ABCD
H R 001234 3 0000 ACD9
H R 1FFFFE 3 0000 5A3C
H R 0ABCDE 3 0000 FBAC
H R 000000 3 0000 A5C3
H R 200000 3 0000 0000
H W A11200 2 0100 0000
H W A11100 2 0100 0000
H C 000000 0 0000 0002
H R A11100 3 0000 A4C3
H R A11200 3 0000 A5C3
H W A00100 2 5A00 0000
H W A00100 1 003C 0000
H R A00100 2 0000 5A5A
H R A00100 1 0000 3C3C
H W A11100 2 0000 0000
H C 000000 0 0000 0003
H W A00100 2 7700 0000
H R A00100 2 0000 FFFF
Z R 0100 0 0000 005A
Z R 0101 0 0000 003C
Z W 0200 0 0099 0000
Z R 2200 0 0000 0099
Z R 5000 0 0000 00FF
Z W 6000 0 0001 0000
Z W 6000 0 0001 0000
Z W 6000 0 0000 0000
Z W 6000 0 0000 0000
Z W 6000 0 0000 0000
Z W 6000 0 0000 0000
Z W 6000 0 0001 0000
Z W 6000 0 0001 0000
Z W 6000 0 0001 0000
H W E18000 3 BEEF 0000
Z R 8000 0 0000 00BE
Z R 8001 0 0000 00EF
Z W 8001 0 0012 0000
H R E18000 3 0000 BE12
